// File: hw/commit_arbiter.sv
////////////////////
// picks one finished unit per cycle, multiplier first
// rd per commit id is recorded at dispatch
////////////////////
`timescale 1ns/1ps
`default_nettype none

module commit_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 issue_valid_i,
    input  logic [long_exec_pkg::ID_W-1:0]       issue_id_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] issue_rd_i,
    input  logic                                 mul_done_i,
    input  logic [long_exec_pkg::XLEN-1:0]       mul_result_i,
    input  logic [long_exec_pkg::ID_W-1:0]       mul_id_i,
    input  logic                                 div_done_i,
    input  logic [long_exec_pkg::XLEN-1:0]       div_result_i,
    input  logic [long_exec_pkg::ID_W-1:0]       div_id_i,
    output logic                                 mul_grant_o,
    output logic                                 div_grant_o,
    output logic                                 commit_valid_o,
    output logic [long_exec_pkg::ID_W-1:0]       commit_id_o,
    output logic [long_exec_pkg::REG_ADDR_W-1:0] commit_rd_o,
    output logic [long_exec_pkg::XLEN-1:0]       commit_data_o
);

    logic [long_exec_pkg::REG_ADDR_W-1:0] rd_tab [long_exec_pkg::NUM_IDS];

    // cleared so a stray id never points at a live reg
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < long_exec_pkg::NUM_IDS; i++) begin
                rd_tab[i] <= '0;
            end
        end else if (issue_valid_i) begin
            rd_tab[issue_id_i] <= issue_rd_i;
        end
    end

    // fixed priority, losing divider keeps done high
    assign mul_grant_o = mul_done_i;
    assign div_grant_o = div_done_i & ~mul_done_i;

    assign commit_valid_o = mul_done_i | div_done_i;
    assign commit_id_o    = mul_done_i ? mul_id_i : div_id_i;
    assign commit_data_o  = mul_done_i ? mul_result_i : div_result_i;
    assign commit_rd_o    = rd_tab[commit_id_o];

endmodule

`default_nettype wire

// File: hw/issue_ctrl.sv
////////////////////
// four-phase req/ack front end
// checks hazards and unit availability, issues once per request,
// writes LI directly and starts mul or div for long ops
////////////////////
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_i,
    input  logic [long_exec_pkg::OP_W-1:0]       op_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [long_exec_pkg::XLEN-1:0]       imm_i,
    output logic                                 ack_o,
    input  logic                                 hazard_stall_i,
    input  logic                                 table_full_i,
    input  logic [long_exec_pkg::ID_W-1:0]       alloc_id_i,
    output logic                                 new_long_valid_o,
    input  logic [long_exec_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [long_exec_pkg::XLEN-1:0]       rs2_data_i,
    input  logic                                 mul_busy_i,
    input  logic                                 div_busy_i,
    output logic                                 mul_start_o,
    output logic                                 div_start_o,
    output logic [long_exec_pkg::XLEN-1:0]       opa_o,
    output logic [long_exec_pkg::XLEN-1:0]       opb_o,
    output logic                                 sel_hi_o,
    output logic [long_exec_pkg::ID_W-1:0]       issue_id_o,
    output logic [long_exec_pkg::REG_ADDR_W-1:0] issue_rd_o,
    output logic                                 li_we_o,
    output logic [long_exec_pkg::REG_ADDR_W-1:0] li_rd_o,
    output logic [long_exec_pkg::XLEN-1:0]       li_data_o
);

    logic is_li;
    logic is_mul;
    logic is_div;
    logic unit_free;
    logic fire;
    logic ack_q;

    assign is_li  = (op_i == long_exec_pkg::OP_LI);
    assign is_mul = (op_i == long_exec_pkg::OP_MUL) || (op_i == long_exec_pkg::OP_MULHU);
    assign is_div = (op_i == long_exec_pkg::OP_DIVU) || (op_i == long_exec_pkg::OP_REMU);

    // long op needs its unit idle and a scoreboard slot
    assign unit_free = (is_mul && !mul_busy_i) || (is_div && !div_busy_i);

    // ack low means this request has not been taken yet
    assign fire = req_i && !ack_q && !hazard_stall_i
                  && (is_li || (unit_free && !table_full_i));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else if (fire) begin
            ack_q <= 1'b1;
        end else if (!req_i) begin
            ack_q <= 1'b0;  // return to idle once source drops req
        end
    end

    assign ack_o = ack_q;

    // dispatch, all sampled at the accepting edge
    assign new_long_valid_o = fire && !is_li;
    assign mul_start_o      = fire && is_mul;
    assign div_start_o      = fire && is_div;
    assign opa_o            = rs1_data_i;  // rf already bypasses commits
    assign opb_o            = rs2_data_i;
    assign sel_hi_o         = (op_i == long_exec_pkg::OP_MULHU) ||
                              (op_i == long_exec_pkg::OP_REMU);  // hi / rem
    assign issue_id_o       = alloc_id_i;
    assign issue_rd_o       = rd_i;

    // LI writes the rf second port at the accept edge
    assign li_we_o   = fire && is_li;
    assign li_rd_o   = rd_i;
    assign li_data_o = imm_i;

endmodule

`default_nettype wire

// File: hw/iter_divider.sv
////////////////////
// restoring unsigned divider, 32 steps plus a select cycle
// done rises 33 cycles after start, held until grant;
// x/0 gives quotient all ones and remainder x
////////////////////
`timescale 1ns/1ps
`default_nettype none

module iter_divider (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [long_exec_pkg::XLEN-1:0] a_i,      // dividend
    input  logic [long_exec_pkg::XLEN-1:0] b_i,      // divisor
    input  logic                           sel_rem_i,
    input  logic [long_exec_pkg::ID_W-1:0] id_i,
    input  logic                           grant_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [long_exec_pkg::XLEN-1:0] result_o,
    output logic [long_exec_pkg::ID_W-1:0] id_o
);

    logic                           running;
    logic [5:0]                     cnt;      // 0..31 steps, 32 select
    logic [long_exec_pkg::XLEN-1:0] rem;
    logic [long_exec_pkg::XLEN-1:0] quo;
    logic [long_exec_pkg::XLEN-1:0] dvsr;
    logic                           sel_rem;
    logic [long_exec_pkg::XLEN:0]   shifted;
    logic [long_exec_pkg::XLEN:0]   diff;
    logic                           ge;

    // trial subtract on the shifted partial remainder
    assign shifted = {rem, quo[31]};
    assign diff    = shifted - {1'b0, dvsr};
    assign ge      = ~diff[32];  // no borrow

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            done_o  <= 1'b0;
            cnt     <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            cnt     <= '0;
        end else if (running) begin
            cnt <= cnt + 6'd1;
            if (cnt == 6'd32) begin  // select cycle
                running <= 1'b0;
                done_o  <= 1'b1;
            end
        end else if (grant_i) begin
            done_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem     <= '0;
            quo     <= a_i;  // dividend shifts out as quotient shifts in
            dvsr    <= b_i;
            sel_rem <= sel_rem_i;
            id_o    <= id_i;
        end else if (running && cnt != 6'd32) begin
            rem <= ge ? diff[31:0] : shifted[31:0];
            quo <= {quo[30:0], ge};
        end else if (running) begin
            // riscv divide by zero rule
            if (dvsr == '0) begin
                result_o <= sel_rem ? rem : '1;
            end else begin
                result_o <= sel_rem ? rem : quo;
            end
        end
    end

    assign busy_o = running | done_o;

endmodule

`default_nettype wire

// File: hw/iter_multiplier.sv
////////////////////
// 32x32 unsigned shift-add multiplier, one bit per cycle
// done rises 32 cycles after start and holds until grant
////////////////////
`timescale 1ns/1ps
`default_nettype none

module iter_multiplier (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [long_exec_pkg::XLEN-1:0] a_i,
    input  logic [long_exec_pkg::XLEN-1:0] b_i,
    input  logic                           sel_hi_i,
    input  logic [long_exec_pkg::ID_W-1:0] id_i,
    input  logic                           grant_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [long_exec_pkg::XLEN-1:0] result_o,
    output logic [long_exec_pkg::ID_W-1:0] id_o
);

    logic                             running;
    logic [4:0]                       cnt;
    logic [long_exec_pkg::XLEN-1:0]   mcand;
    logic [2*long_exec_pkg::XLEN-1:0] prod;   // {acc, multiplier bits left}
    logic                             sel_hi;
    logic [long_exec_pkg::XLEN:0]     sum;    // carry out kept

    // add multiplicand into the upper half when lsb set
    assign sum = prod[0] ? {1'b0, prod[63:32]} + {1'b0, mcand}
                         : {1'b0, prod[63:32]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            done_o  <= 1'b0;
            cnt     <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            cnt     <= '0;
        end else if (running) begin
            cnt <= cnt + 5'd1;
            if (cnt == 5'd31) begin  // last step
                running <= 1'b0;
                done_o  <= 1'b1;
            end
        end else if (grant_i) begin
            done_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand  <= a_i;
            prod   <= {32'd0, b_i};
            sel_hi <= sel_hi_i;
            id_o   <= id_i;
        end else if (running) begin
            prod <= {sum, prod[31:1]};  // shift right one
        end
    end

    assign busy_o   = running | done_o;  // idle only after grant
    assign result_o = sel_hi ? prod[63:32] : prod[31:0];

endmodule

`default_nettype wire

// File: hw/long_exec_pkg.sv
////////////////////
// shared widths, opcode encoding and scoreboard size for long_exec
// referenced as long_exec_pkg::name from every rtl file
////////////////////
`default_nettype none

package long_exec_pkg;

    localparam int XLEN       = 32;  // data path width
    localparam int REG_ADDR_W = 5;   // 32 architectural regs
    localparam int ID_W       = 2;   // commit id width
    localparam int NUM_IDS    = 4;   // scoreboard entries, long ops in flight
    localparam int OP_W       = 3;

    // opcode encoding, LI is the only short op
    localparam logic [OP_W-1:0] OP_LI    = 3'd0;
    localparam logic [OP_W-1:0] OP_MUL   = 3'd1;  // low word of product
    localparam logic [OP_W-1:0] OP_MULHU = 3'd2;  // high word, unsigned
    localparam logic [OP_W-1:0] OP_DIVU  = 3'd3;
    localparam logic [OP_W-1:0] OP_REMU  = 3'd4;

endpackage

`default_nettype wire

// File: hw/long_exec_top.sv
////////////////////
// long-latency execution subsystem top
// one instruction per four-phase req/ack, results on two wb ports
////////////////////
`timescale 1ns/1ps
`default_nettype none

module long_exec_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_i,
    input  logic [long_exec_pkg::OP_W-1:0]       op_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [long_exec_pkg::XLEN-1:0]       imm_i,
    output logic                                 ack_o,
    output logic                                 short_wb_valid_o,
    output logic [long_exec_pkg::REG_ADDR_W-1:0] short_wb_rd_o,
    output logic [long_exec_pkg::XLEN-1:0]       short_wb_data_o,
    output logic                                 long_wb_valid_o,
    output logic [long_exec_pkg::REG_ADDR_W-1:0] long_wb_rd_o,
    output logic [long_exec_pkg::XLEN-1:0]       long_wb_data_o,
    output logic                                 busy_o
);

    logic                                 hazard_stall;
    logic                                 table_full;
    logic [long_exec_pkg::ID_W-1:0]       alloc_id;
    logic                                 new_long_valid;
    logic [long_exec_pkg::XLEN-1:0]       rs1_data;
    logic [long_exec_pkg::XLEN-1:0]       rs2_data;
    logic                                 mul_busy;
    logic                                 div_busy;
    logic                                 mul_start;
    logic                                 div_start;
    logic [long_exec_pkg::XLEN-1:0]       opa;
    logic [long_exec_pkg::XLEN-1:0]       opb;
    logic                                 sel_hi;
    logic [long_exec_pkg::ID_W-1:0]       issue_id;
    logic [long_exec_pkg::REG_ADDR_W-1:0] issue_rd;
    logic                                 mul_done;
    logic                                 div_done;
    logic [long_exec_pkg::XLEN-1:0]       mul_result;
    logic [long_exec_pkg::XLEN-1:0]       div_result;
    logic [long_exec_pkg::ID_W-1:0]       mul_id;
    logic [long_exec_pkg::ID_W-1:0]       div_id;
    logic                                 mul_grant;
    logic                                 div_grant;
    logic [long_exec_pkg::ID_W-1:0]       commit_id;

    long_hazard_unit u_hazard (
        .clk, .rst_n,
        .new_long_valid_i (new_long_valid),
        .new_rd_i         (issue_rd),
        .new_rs1_i        (rs1_i),
        .new_rs2_i        (rs2_i),
        .new_rd_we_i      (1'b1),  // every op writes rd
        .commit_valid_i   (long_wb_valid_o),
        .commit_id_i      (commit_id),
        .hazard_stall_o   (hazard_stall),
        .alloc_id_o       (alloc_id),
        .table_full_o     (table_full),
        .lock_o           (busy_o)
    );

    issue_ctrl u_issue (
        .clk, .rst_n, .req_i, .op_i, .rd_i, .rs1_i, .rs2_i, .imm_i, .ack_o,
        .hazard_stall_i   (hazard_stall),
        .table_full_i     (table_full),
        .alloc_id_i       (alloc_id),
        .new_long_valid_o (new_long_valid),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .mul_busy_i       (mul_busy),
        .div_busy_i       (div_busy),
        .mul_start_o      (mul_start),
        .div_start_o      (div_start),
        .opa_o            (opa),
        .opb_o            (opb),
        .sel_hi_o         (sel_hi),
        .issue_id_o       (issue_id),
        .issue_rd_o       (issue_rd),
        .li_we_o          (short_wb_valid_o),
        .li_rd_o          (short_wb_rd_o),
        .li_data_o        (short_wb_data_o)
    );

    iter_multiplier u_mul (
        .clk, .rst_n,
        .start_i (mul_start), .a_i (opa), .b_i (opb), .sel_hi_i (sel_hi),
        .id_i (issue_id), .grant_i (mul_grant), .busy_o (mul_busy),
        .done_o (mul_done), .result_o (mul_result), .id_o (mul_id)
    );

    iter_divider u_div (
        .clk, .rst_n,
        .start_i (div_start), .a_i (opa), .b_i (opb), .sel_rem_i (sel_hi),
        .id_i (issue_id), .grant_i (div_grant), .busy_o (div_busy),
        .done_o (div_done), .result_o (div_result), .id_o (div_id)
    );

    commit_arbiter u_arb (
        .clk, .rst_n,
        .issue_valid_i  (new_long_valid),
        .issue_id_i     (issue_id),
        .issue_rd_i     (issue_rd),
        .mul_done_i     (mul_done),
        .mul_result_i   (mul_result),
        .mul_id_i       (mul_id),
        .div_done_i     (div_done),
        .div_result_i   (div_result),
        .div_id_i       (div_id),
        .mul_grant_o    (mul_grant),
        .div_grant_o    (div_grant),
        .commit_valid_o (long_wb_valid_o),
        .commit_id_o    (commit_id),
        .commit_rd_o    (long_wb_rd_o),
        .commit_data_o  (long_wb_data_o)
    );

    // port a long commit, port b LI
    reg_file u_rf (
        .clk, .rst_n,
        .wa_we_i   (long_wb_valid_o),
        .wa_addr_i (long_wb_rd_o),
        .wa_data_i (long_wb_data_o),
        .wb_we_i   (short_wb_valid_o),
        .wb_addr_i (short_wb_rd_o),
        .wb_data_i (short_wb_data_o),
        .ra_addr_i (rs1_i),
        .ra_data_o (rs1_data),
        .rb_addr_i (rs2_i),
        .rb_data_o (rs2_data)
    );

endmodule

`default_nettype wire

// File: hw/long_hazard_unit.sv
////////////////////
// scoreboard for long ops in flight
// flags raw/waw against pending rd, hands out commit ids,
// lock is high while any entry is valid
////////////////////
`timescale 1ns/1ps
`default_nettype none

module long_hazard_unit (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   new_long_valid_i,  // accepted long op
    input  logic [long_exec_pkg::REG_ADDR_W-1:0]   new_rd_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0]   new_rs1_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0]   new_rs2_i,
    input  logic                                   new_rd_we_i,
    input  logic                                   commit_valid_i,
    input  logic [long_exec_pkg::ID_W-1:0]         commit_id_i,
    output logic                                   hazard_stall_o,
    output logic [long_exec_pkg::ID_W-1:0]         alloc_id_o,
    output logic                                   table_full_o,
    output logic                                   lock_o
);

    logic [long_exec_pkg::NUM_IDS-1:0]    ent_valid;
    logic [long_exec_pkg::REG_ADDR_W-1:0] ent_rd [long_exec_pkg::NUM_IDS];
    logic                                 raw_hit;
    logic                                 waw_hit;

    // x0 never creates a dependency
    always_comb begin
        raw_hit = 1'b0;
        waw_hit = 1'b0;
        for (int i = 0; i < long_exec_pkg::NUM_IDS; i++) begin
            // entry retiring this cycle is already visible through the rf bypass
            if (ent_valid[i] && !(commit_valid_i && int'(commit_id_i) == i)) begin
                if ((new_rs1_i != '0 && new_rs1_i == ent_rd[i]) ||
                    (new_rs2_i != '0 && new_rs2_i == ent_rd[i])) begin
                    raw_hit = 1'b1;
                end
                if (new_rd_we_i && new_rd_i != '0 && new_rd_i == ent_rd[i]) begin
                    waw_hit = 1'b1;  // keep write-back order per rd
                end
            end
        end
    end

    assign hazard_stall_o = raw_hit | waw_hit;

    // lowest free slot wins, scan downwards so the last hit is the lowest
    always_comb begin
        alloc_id_o = '0;
        for (int i = long_exec_pkg::NUM_IDS - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                alloc_id_o = i[long_exec_pkg::ID_W-1:0];
            end
        end
    end

    assign table_full_o = &ent_valid;  // retiring slot not reused same cycle
    assign lock_o       = |ent_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else begin
            if (commit_valid_i) begin
                ent_valid[commit_id_i] <= 1'b0;
            end
            if (new_long_valid_i) begin
                ent_valid[alloc_id_o] <= 1'b1;  // never the committing slot
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_long_valid_i) begin
            ent_rd[alloc_id_o] <= new_rd_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
////////////////////
// 32x32 register file, x0 reads zero
// port a takes long commits, port b takes LI; reads bypass both
////////////////////
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wa_we_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] wa_addr_i,
    input  logic [long_exec_pkg::XLEN-1:0]       wa_data_i,
    input  logic                                 wb_we_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [long_exec_pkg::XLEN-1:0]       wb_data_i,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] ra_addr_i,
    output logic [long_exec_pkg::XLEN-1:0]       ra_data_o,
    input  logic [long_exec_pkg::REG_ADDR_W-1:0] rb_addr_i,
    output logic [long_exec_pkg::XLEN-1:0]       rb_data_o
);

    logic [long_exec_pkg::XLEN-1:0] regs [32];

    // architectural state starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wa_we_i && wa_addr_i != '0) begin
                regs[wa_addr_i] <= wa_data_i;
            end
            if (wb_we_i && wb_addr_i != '0) begin  // waw stall keeps a and b apart
                regs[wb_addr_i] <= wb_data_i;
            end
        end
    end

    // same-cycle write wins over the stored value
    assign ra_data_o = (ra_addr_i == '0)                    ? '0 :
                       (wa_we_i && wa_addr_i == ra_addr_i)  ? wa_data_i :
                       (wb_we_i && wb_addr_i == ra_addr_i)  ? wb_data_i : regs[ra_addr_i];
    assign rb_data_o = (rb_addr_i == '0)                    ? '0 :
                       (wa_we_i && wa_addr_i == rb_addr_i)  ? wa_data_i :
                       (wb_we_i && wb_addr_i == rb_addr_i)  ? wb_data_i : regs[rb_addr_i];

endmodule

`default_nettype wire

// File: long_exec.f
hw/long_exec_pkg.sv
hw/long_hazard_unit.sv
hw/issue_ctrl.sv
hw/iter_multiplier.sv
hw/iter_divider.sv
hw/commit_arbiter.sv
hw/reg_file.sv
hw/long_exec_top.sv
tests/long_exec_checker.sv
tests/long_exec_tb.sv

// File: tests/long_exec_checker.sv
////////////////////
// write-back checker for long_exec_top
// holds one expected-value FIFO per register, filled by the testbench
// in program order and popped on every write-back to a nonzero rd
////////////////////
`timescale 1ns/1ps
`default_nettype none

module long_exec_checker (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 short_wb_valid_i,
    input  wire logic [long_exec_pkg::REG_ADDR_W-1:0] short_wb_rd_i,
    input  wire logic [long_exec_pkg::XLEN-1:0]       short_wb_data_i,
    input  wire logic                                 long_wb_valid_i,
    input  wire logic [long_exec_pkg::REG_ADDR_W-1:0] long_wb_rd_i,
    input  wire logic [long_exec_pkg::XLEN-1:0]       long_wb_data_i,
    output int                                        errors_o,
    output int                                        pending_o
);

    localparam int DEPTH = 8;  // per-reg slots, waw stall keeps this small

    logic [long_exec_pkg::XLEN-1:0] exp_mem [32][DEPTH];
    int head  [32];
    int count [32];
    int errors  = 0;
    int pending = 0;  // expected writes not yet seen

    initial begin
        for (int i = 0; i < 32; i++) begin
            head[i]  = 0;
            count[i] = 0;
        end
    end

    // called by the testbench before the request goes out
    task automatic expect_write(input logic [4:0] rd, input logic [31:0] data);
        if (rd != '0) begin
            if (count[rd] == DEPTH) begin
                $display("ERROR: expected-value FIFO for x%0d overflowed", rd);
                errors++;
            end else begin
                exp_mem[rd][(head[rd] + count[rd]) % DEPTH] = data;
                count[rd]++;
                pending++;
            end
        end
    endtask

    task automatic check_wb(input string kind, input logic [4:0] rd, input logic [31:0] data);
        logic [31:0] exp;
        if (rd != '0) begin  // x0 writes are dropped by the rf
            if (count[rd] == 0) begin
                $display("ERROR: unexpected %s write-back to x%0d at %0t", kind, rd, $time);
                errors++;
            end else begin
                exp      = exp_mem[rd][head[rd]];
                head[rd] = (head[rd] + 1) % DEPTH;
                count[rd]--;
                pending--;
                if (data !== exp) begin
                    $display("Mismatch at %0t: %s write-back x%0d got %h expected %h",
                             $time, kind, rd, data, exp);
                    errors++;
                end
            end
        end
    endtask

    // mid-cycle sample, valids are stable between edges
    always @(negedge clk) begin
        if (rst_n) begin
            // a commit is older than an LI to the same rd in the same cycle
            if (long_wb_valid_i) check_wb("long", long_wb_rd_i, long_wb_data_i);
            if (short_wb_valid_i) check_wb("short", short_wb_rd_i, short_wb_data_i);
        end
    end

    assign errors_o  = errors;
    assign pending_o = pending;

endmodule

`default_nettype wire

// File: tests/long_exec_tb.sv
////////////////////
// testbench for long_exec_top
// directed then random instructions over req/ack, a reference model
// queues expected write-backs in the checker
////////////////////
`timescale 1ns/1ps
`default_nettype none

module long_exec_tb;

    localparam int SEED     = 58944;
    localparam int NUM_RAND = 300;  // random stream length
    localparam int MAX_WAIT = 500;  // cycles allowed per wait

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req;
    logic [2:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        ack;
    logic        short_wb_valid;
    logic [4:0]  short_wb_rd;
    logic [31:0] short_wb_data;
    logic        long_wb_valid;
    logic [4:0]  long_wb_rd;
    logic [31:0] long_wb_data;
    logic        busy;
    int          chk_errors;
    int          chk_pending;
    int          tb_errors = 0;
    logic [31:0] model_regs [32];  // architectural state in program order

    always #5 clk = ~clk;

    long_exec_top u_long_exec_top (
        .clk, .rst_n, .req_i (req), .op_i (op), .rd_i (rd), .rs1_i (rs1), .rs2_i (rs2),
        .imm_i (imm), .ack_o (ack), .short_wb_valid_o (short_wb_valid),
        .short_wb_rd_o (short_wb_rd), .short_wb_data_o (short_wb_data),
        .long_wb_valid_o (long_wb_valid), .long_wb_rd_o (long_wb_rd),
        .long_wb_data_o (long_wb_data), .busy_o (busy)
    );

    long_exec_checker u_checker (
        .clk, .rst_n, .short_wb_valid_i (short_wb_valid), .short_wb_rd_i (short_wb_rd),
        .short_wb_data_i (short_wb_data), .long_wb_valid_i (long_wb_valid),
        .long_wb_rd_i (long_wb_rd), .long_wb_data_i (long_wb_data),
        .errors_o (chk_errors), .pending_o (chk_pending)
    );

    // unsigned riscv semantics, x/0 gives all ones and remainder x
    function automatic logic [31:0] ref_result(input logic [2:0] f_op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [31:0] f_imm);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (f_op)
            long_exec_pkg::OP_LI:    return f_imm;
            long_exec_pkg::OP_MUL:   return prod[31:0];
            long_exec_pkg::OP_MULHU: return prod[63:32];
            long_exec_pkg::OP_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            default:                 return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR: %s at %0t", why, $time);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // one full four-phase transfer, entered and left 1 ns after a rising edge
    task automatic send_instr(input logic [2:0] t_op, input logic [4:0] t_rd,
                              input logic [4:0] t_rs1, input logic [4:0] t_rs2,
                              input logic [31:0] t_imm);
        logic [31:0] res;
        int          cnt;
        res = ref_result(t_op, model_regs[t_rs1], model_regs[t_rs2], t_imm);
        if (t_rd != '0) model_regs[t_rd] = res;  // x0 stays zero
        u_checker.expect_write(t_rd, res);  // queued before LI can write
        op  = t_op;
        rd  = t_rd;
        rs1 = t_rs1;
        rs2 = t_rs2;
        imm = t_imm;
        req = 1'b1;
        cnt = 0;
        while (!ack && cnt < MAX_WAIT) begin  // stalls keep ack low
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!ack) abort_run("no ack for a pending request");
        if (t_op != long_exec_pkg::OP_LI && !busy) begin
            $display("Mismatch at %0t: busy_o low with a long op in flight", $time);
            tb_errors++;
        end
        req = 1'b0;
        cnt = 0;
        while (ack && cnt < MAX_WAIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (ack) abort_run("ack_o stuck high after req dropped");
    endtask

    // all long ops committed, nothing left in the expected FIFOs
    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (busy && cnt < MAX_WAIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (busy) abort_run("busy_o never dropped");
        if (chk_pending != 0) begin
            $display("ERROR: %0d write-backs never arrived", chk_pending);
            tb_errors++;
        end
    endtask

    initial begin
        int seed_val;
        seed_val = $urandom(SEED);
        rst_n = 1'b0;
        req   = 1'b0;
        op    = '0;
        rd    = '0;
        rs1   = '0;
        rs2   = '0;
        imm   = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;  // rf resets to zero
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (busy || ack) begin
            $display("Mismatch at %0t: busy_o or ack_o high after reset", $time);
            tb_errors++;
        end
        // LI to every reg, x0 included
        for (int i = 0; i < 32; i++) send_instr(long_exec_pkg::OP_LI, i, 0, 0, $urandom);
        // full-range products and divide by zero
        send_instr(long_exec_pkg::OP_LI, 1, 0, 0, 32'hffff_ffff);
        send_instr(long_exec_pkg::OP_LI, 2, 0, 0, 32'hffff_fffe);
        send_instr(long_exec_pkg::OP_MUL, 3, 1, 2, 0);
        send_instr(long_exec_pkg::OP_MULHU, 4, 1, 2, 0);
        send_instr(long_exec_pkg::OP_DIVU, 5, 1, 0, 0);
        send_instr(long_exec_pkg::OP_REMU, 6, 2, 0, 0);
        send_instr(long_exec_pkg::OP_DIVU, 7, 4, 3, 0);  // raw on both mul results
        send_instr(long_exec_pkg::OP_REMU, 8, 1, 7, 0);
        send_instr(long_exec_pkg::OP_MUL, 9, 0, 8, 0);  // x0 still zero
        wait_idle();
        // raw chain mixing short and long ops
        send_instr(long_exec_pkg::OP_LI, 10, 0, 0, 32'd1234567);
        send_instr(long_exec_pkg::OP_MUL, 11, 10, 10, 0);
        send_instr(long_exec_pkg::OP_DIVU, 12, 11, 10, 0);
        send_instr(long_exec_pkg::OP_LI, 13, 0, 0, 32'd7);
        send_instr(long_exec_pkg::OP_REMU, 14, 12, 13, 0);
        send_instr(long_exec_pkg::OP_MULHU, 15, 14, 11, 0);
        // waw on x16 from div, then mul, then LI
        send_instr(long_exec_pkg::OP_DIVU, 16, 11, 13, 0);
        send_instr(long_exec_pkg::OP_MUL, 16, 10, 13, 0);
        send_instr(long_exec_pkg::OP_LI, 16, 0, 0, 32'h5a5a_5a5a);
        send_instr(long_exec_pkg::OP_MUL, 17, 16, 16, 0);
        wait_idle();
        // burst of independent long ops, more than the scoreboard holds
        for (int i = 0; i < 6; i++) begin
            send_instr((i % 2) ? long_exec_pkg::OP_DIVU : long_exec_pkg::OP_MUL,
                       20 + i, 1, 10, 0);
        end
        wait_idle();
        // random stream on a few regs so hazards are frequent
        for (int n = 0; n < NUM_RAND; n++) begin
            send_instr($urandom % 5, $urandom % 8, $urandom % 8, $urandom % 8, $urandom);
        end
        wait_idle();
        $display("checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
